/* Makefile */
# Verilator simulation of the metadata router testbench
# usage: make sim, make clean, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_p4_router
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "TEST PASS" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* source/egress_port_encode.sv */
/* result stage, converts the chosen p4 egress id back to an rtl egress index
   and registers the outgoing metadata word with its valid strobe */
`timescale 1ns/1ps
`default_nettype none

module egress_port_encode (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       act_valid,
    input  router_pkg::port_id_t       act_ingress_id,           // p4 ingress id
    input  router_pkg::port_id_t       act_egress_id,            // p4 egress id
    output router_pkg::user_metadata_t user_metadata_out,        // {p4 ingress, rtl egress}
    output logic                       user_metadata_out_valid
);

    import router_pkg::*;

    ////////////////////////////////////////
    // p4 id to rtl index

    function automatic port_id_t egress_map(input port_id_t p4_id);
        case (p4_id)
            CPU_P4_ID   : return CPU_RTL_ID;
            OISL0_P4_ID : return OISL0_RTL_ID;
            OISL1_P4_ID : return OISL1_RTL_ID;
            ECP0_P4_ID  : return ECP0_RTL_ID;
            ECP1_P4_ID  : return ECP1_RTL_ID;
            HDR0_P4_ID  : return HDR0_RTL_ID;
            HDR1_P4_ID  : return HDR1_RTL_ID;
            ECG0_P4_ID  : return ECG0_RTL_ID;
            ECG1_P4_ID  : return ECG1_RTL_ID;
            ECG2_P4_ID  : return ECG2_RTL_ID;
            ECG3_P4_ID  : return ECG3_RTL_ID;
            default     : return UNKNOWN_PORT_ID;   // unlisted id is still forwarded
        endcase
    endfunction

    port_id_t       rtl_egress_idx;   // mapped egress index
    user_metadata_t out_word;         // assembled output word

    assign rtl_egress_idx = egress_map(act_egress_id);

    // same field layout as the input word
    assign out_word[EGR_SPEC_ID_WIDTH +: ING_PORT_ID_WIDTH] = act_ingress_id;
    assign out_word[0 +: EGR_SPEC_ID_WIDTH]                 = rtl_egress_idx;

    ////////////////////////////////////////
    // stage register

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            user_metadata_out_valid <= 1'b0;
        end else begin
            user_metadata_out_valid <= act_valid;   // one cycle per descriptor
        end
    end

    always_ff @(posedge clk) begin
        if (act_valid) begin
            user_metadata_out <= out_word;   // held between descriptors
        end
    end

endmodule

`default_nettype wire

/* source/match_action_table.sv */
/* execute stage, looks up (p4 ingress id, flow tag) in a small programmable
   rule table and picks the p4 egress id, falling back to the cpu on a miss */
`timescale 1ns/1ps
`default_nettype none

module match_action_table (
    input  logic                  clk,
    input  logic                  rst_n,
    // descriptor from decode
    input  logic                  dec_valid,
    input  router_pkg::port_id_t  dec_ingress_id,
    input  router_pkg::flow_tag_t dec_flow_tag,
    // rule write port
    input  logic                  rule_wr_en,           // single cycle strobe
    input  router_pkg::rule_idx_t rule_wr_idx,
    input  logic                  rule_wr_enable_bit,   // 0 disables the slot
    input  router_pkg::port_id_t  rule_wr_ingress_id,
    input  router_pkg::flow_tag_t rule_wr_flow_tag,
    input  router_pkg::port_id_t  rule_wr_egress_id,
    // result to encode stage
    output logic                  act_valid,
    output router_pkg::port_id_t  act_ingress_id,       // carried through for the output word
    output router_pkg::port_id_t  act_egress_id,        // p4 egress id
    output logic                  table_miss            // pulses with act_valid on a miss
);

    import router_pkg::*;

    ////////////////////////////////////////
    // rule storage

    logic      rule_en  [NUM_RULES];   // per slot enable, cleared by reset
    port_id_t  rule_ing [NUM_RULES];   // ingress id key
    flow_tag_t rule_tag [NUM_RULES];   // flow tag key
    port_id_t  rule_egr [NUM_RULES];   // egress id action

    // only the enable bits are control state
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_RULES; i++) begin
                rule_en[i] <= 1'b0;
            end
        end else if (rule_wr_en) begin
            rule_en[rule_wr_idx] <= rule_wr_enable_bit;
        end
    end

    always_ff @(posedge clk) begin
        if (rule_wr_en) begin
            rule_ing[rule_wr_idx] <= rule_wr_ingress_id;
            rule_tag[rule_wr_idx] <= rule_wr_flow_tag;
            rule_egr[rule_wr_idx] <= rule_wr_egress_id;
        end
    end

    ////////////////////////////////////////
    // parallel match

    logic [NUM_RULES-1:0] match_vec;          // one bit per enabled matching slot
    logic                 lookup_hit;
    rule_idx_t            hit_idx;            // lowest matching slot
    port_id_t             lookup_egress_id;

    // all slots compared at once against the registered key
    always_comb begin
        for (int i = 0; i < NUM_RULES; i++) begin
            match_vec[i] = rule_en[i]
                         & (rule_ing[i] == dec_ingress_id)
                         & (rule_tag[i] == dec_flow_tag);
        end
    end

    assign lookup_hit = |match_vec;

    // scan from the top so the lowest index is assigned last and wins
    always_comb begin
        hit_idx = '0;
        for (int i = NUM_RULES - 1; i >= 0; i--) begin
            if (match_vec[i]) begin
                hit_idx = rule_idx_t'(i);
            end
        end
    end

    // default action sends the packet to the cpu
    assign lookup_egress_id = lookup_hit ? rule_egr[hit_idx] : CPU_P4_ID;

    ////////////////////////////////////////
    // stage register

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            act_valid  <= 1'b0;
            table_miss <= 1'b0;
        end else begin
            act_valid  <= dec_valid;
            table_miss <= dec_valid & ~lookup_hit;   // no enabled rule matched
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            act_ingress_id <= dec_ingress_id;     // unchanged
            act_egress_id  <= lookup_egress_id;
        end
    end

endmodule

`default_nettype wire

/* source/p4_router_top.sv */
/* top level of the metadata router, chains decode, match-action and encode
   stages and exposes the descriptor ports and the rule write strobe */
`timescale 1ns/1ps
`default_nettype none

module p4_router_top (
    input  logic                       clk,
    input  logic                       rst_n,
    // descriptor in
    input  router_pkg::user_metadata_t user_metadata_in,
    input  logic                       user_metadata_in_valid,
    // rule write port
    input  logic                       rule_wr_en,
    input  router_pkg::rule_idx_t      rule_wr_idx,
    input  logic                       rule_wr_enable_bit,
    input  router_pkg::port_id_t       rule_wr_ingress_id,
    input  router_pkg::flow_tag_t      rule_wr_flow_tag,
    input  router_pkg::port_id_t       rule_wr_egress_id,
    // descriptor out, three cycles after input
    output router_pkg::user_metadata_t user_metadata_out,
    output logic                       user_metadata_out_valid,
    // events
    output logic                       ingress_drop,   // unknown rtl ingress
    output logic                       table_miss      // forwarded to cpu by default
);

    import router_pkg::*;

    ////////////////////////////////////////
    // stage links

    logic      dec_valid;        // decode to execute
    port_id_t  dec_ingress_id;
    flow_tag_t dec_flow_tag;

    logic      act_valid;        // execute to result
    port_id_t  act_ingress_id;
    port_id_t  act_egress_id;

    port_id_decode decode_i (
        .clk                    ( clk                    ),
        .rst_n                  ( rst_n                  ),
        .user_metadata_in       ( user_metadata_in       ),
        .user_metadata_in_valid ( user_metadata_in_valid ),
        .dec_valid              ( dec_valid              ),
        .dec_ingress_id         ( dec_ingress_id         ),
        .dec_flow_tag           ( dec_flow_tag           ),
        .ingress_drop           ( ingress_drop           )
    );

    match_action_table execute_i (
        .clk                ( clk                ),
        .rst_n              ( rst_n              ),
        .dec_valid          ( dec_valid          ),
        .dec_ingress_id     ( dec_ingress_id     ),
        .dec_flow_tag       ( dec_flow_tag       ),
        .rule_wr_en         ( rule_wr_en         ),
        .rule_wr_idx        ( rule_wr_idx        ),
        .rule_wr_enable_bit ( rule_wr_enable_bit ),
        .rule_wr_ingress_id ( rule_wr_ingress_id ),
        .rule_wr_flow_tag   ( rule_wr_flow_tag   ),
        .rule_wr_egress_id  ( rule_wr_egress_id  ),
        .act_valid          ( act_valid          ),
        .act_ingress_id     ( act_ingress_id     ),
        .act_egress_id      ( act_egress_id      ),
        .table_miss         ( table_miss         )
    );

    egress_port_encode result_i (
        .clk                     ( clk                     ),
        .rst_n                   ( rst_n                   ),
        .act_valid               ( act_valid               ),
        .act_ingress_id          ( act_ingress_id          ),
        .act_egress_id           ( act_egress_id           ),
        .user_metadata_out       ( user_metadata_out       ),
        .user_metadata_out_valid ( user_metadata_out_valid )
    );

endmodule

`default_nettype wire

/* source/port_id_decode.sv */
/* decode stage, maps the rtl ingress index of each descriptor to its p4 id
   and drops descriptors whose ingress index is not a known port */
`timescale 1ns/1ps
`default_nettype none

module port_id_decode (
    input  logic                       clk,
    input  logic                       rst_n,
    input  router_pkg::user_metadata_t user_metadata_in,        // {rtl ingress, flow tag}
    input  logic                       user_metadata_in_valid,
    output logic                       dec_valid,               // known ingress only
    output router_pkg::port_id_t       dec_ingress_id,          // p4 ingress id
    output router_pkg::flow_tag_t      dec_flow_tag,
    output logic                       ingress_drop             // one pulse per dropped input
);

    import router_pkg::*;

    ////////////////////////////////////////
    // rtl index to p4 id

    function automatic port_id_t ingress_map(input port_id_t rtl_idx);
        case (rtl_idx)
            CPU_RTL_ID   : return CPU_P4_ID;
            OISL0_RTL_ID : return OISL0_P4_ID;
            OISL1_RTL_ID : return OISL1_P4_ID;
            ECP0_RTL_ID  : return ECP0_P4_ID;
            ECP1_RTL_ID  : return ECP1_P4_ID;
            HDR0_RTL_ID  : return HDR0_P4_ID;
            HDR1_RTL_ID  : return HDR1_P4_ID;
            ECG0_RTL_ID  : return ECG0_P4_ID;
            ECG1_RTL_ID  : return ECG1_P4_ID;
            ECG2_RTL_ID  : return ECG2_P4_ID;
            ECG3_RTL_ID  : return ECG3_P4_ID;
            default      : return UNKNOWN_PORT_ID;   // index 11 and up
        endcase
    endfunction

    port_id_t  in_rtl_ingress;   // upper field of input word
    flow_tag_t in_flow_tag;      // lower field of input word
    port_id_t  in_p4_ingress;    // mapped id, may be unknown
    logic      in_known;         // mapping found

    assign in_rtl_ingress = user_metadata_in[EGR_SPEC_ID_WIDTH +: ING_PORT_ID_WIDTH];
    assign in_flow_tag    = user_metadata_in[0 +: EGR_SPEC_ID_WIDTH];
    assign in_p4_ingress  = ingress_map(in_rtl_ingress);
    assign in_known       = (in_p4_ingress != UNKNOWN_PORT_ID);

    ////////////////////////////////////////
    // stage register

    // valid and drop are mutually exclusive for any accepted input
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid    <= 1'b0;
            ingress_drop <= 1'b0;
        end else begin
            dec_valid    <= user_metadata_in_valid & in_known;
            ingress_drop <= user_metadata_in_valid & ~in_known;   // lasts one cycle
        end
    end

    always_ff @(posedge clk) begin
        if (user_metadata_in_valid) begin   // hold payload when idle
            dec_ingress_id <= in_p4_ingress;
            dec_flow_tag   <= in_flow_tag;  // tag passes unchanged
        end
    end

endmodule

`default_nettype wire

/* source/router_pkg.sv */
/* shared widths, vector types and port encodings for the metadata router
   pipeline, imported by every stage and by the top level */

package router_pkg;

    ////////////////////////////////////////
    // field widths

    localparam int ING_PORT_ID_WIDTH   = 8;    // upper field of the metadata word
    localparam int EGR_SPEC_ID_WIDTH   = 8;    // lower field, tag in and egress out
    localparam int USER_METADATA_WIDTH = ING_PORT_ID_WIDTH + EGR_SPEC_ID_WIDTH;

    localparam int NUM_RULES = 8;              // match-action table depth

    ////////////////////////////////////////
    // vector types

    typedef logic [ING_PORT_ID_WIDTH-1:0]   port_id_t;       // rtl index or p4 id
    typedef logic [EGR_SPEC_ID_WIDTH-1:0]   flow_tag_t;      // flow tag from input word
    typedef logic [USER_METADATA_WIDTH-1:0] user_metadata_t; // {ingress, egress/tag}
    typedef logic [$clog2(NUM_RULES)-1:0]   rule_idx_t;      // rule table slot

    ////////////////////////////////////////
    // rtl port indices

    // one index space shared by ingress and egress
    typedef enum logic [ING_PORT_ID_WIDTH-1:0] {
        CPU_RTL_ID,     // 0, host port
        OISL0_RTL_ID,   // optical inter-satellite links
        OISL1_RTL_ID,
        ECP0_RTL_ID,    // ecp pair
        ECP1_RTL_ID,
        HDR0_RTL_ID,    // high data rate links
        HDR1_RTL_ID,
        ECG0_RTL_ID,    // ecg group
        ECG1_RTL_ID,
        ECG2_RTL_ID,
        ECG3_RTL_ID     // 10, last valid index
    } rtl_port_e;

    ////////////////////////////////////////
    // p4 port ids

    // ids as seen by the p4 program, grouped by tens per port family
    localparam port_id_t CPU_P4_ID   = 8'd0;
    localparam port_id_t OISL0_P4_ID = 8'd20;
    localparam port_id_t OISL1_P4_ID = 8'd21;
    localparam port_id_t ECP0_P4_ID  = 8'd40;
    localparam port_id_t ECP1_P4_ID  = 8'd41;
    localparam port_id_t HDR0_P4_ID  = 8'd60;
    localparam port_id_t HDR1_P4_ID  = 8'd61;
    localparam port_id_t ECG0_P4_ID  = 8'd80;
    localparam port_id_t ECG1_P4_ID  = 8'd81;
    localparam port_id_t ECG2_P4_ID  = 8'd82;
    localparam port_id_t ECG3_P4_ID  = 8'd83;

    // returned by either map when an id has no counterpart
    localparam port_id_t UNKNOWN_PORT_ID = 8'hFF;

endpackage

/* src.f */
+incdir+test
source/router_pkg.sv
source/port_id_decode.sv
source/match_action_table.sv
source/egress_port_encode.sv
source/p4_router_top.sv
test/tb_p4_router.sv

/* test/tb_router_tasks.svh */
/* directed tests and stimulus helpers, included in the router testbench
   module, every task starts and ends on a falling clock edge */

////////////////////////////////////////
// stimulus helpers

task automatic write_rule(input rule_idx_t idx, input logic en, input port_id_t ing,
                          input flow_tag_t tag, input port_id_t egr);
    rule_wr_en         = 1'b1;   // single strobe
    rule_wr_idx        = idx;
    rule_wr_enable_bit = en;
    rule_wr_ingress_id = ing;
    rule_wr_flow_tag   = tag;
    rule_wr_egress_id  = egr;
    @(negedge clk);
    rule_wr_en     = 1'b0;
    model_en[idx]  = en;
    model_ing[idx] = ing;
    model_tag[idx] = tag;
    model_egr[idx] = egr;
endtask

task automatic clear_rules();
    for (int r = 0; r < NUM_RULES; r++) begin
        write_rule(rule_idx_t'(r), 1'b0, 8'd0, 8'd0, 8'd0);
    end
endtask

// drives one descriptor for the coming edge and queues what it should cause
task automatic drive_desc(input port_id_t rtl_ing, input flow_tag_t tag);
    port_id_t p4_ing;
    port_id_t p4_egr;
    logic     hit;
    user_metadata_in       = {rtl_ing, tag};
    user_metadata_in_valid = 1'b1;
    p4_ing = p4_of_rtl(rtl_ing);
    if (p4_ing == NO_MAP) begin
        drop_cycle_q.push_back(cycle + 1);   // decode stage
    end else begin
        p4_egr = model_lookup(p4_ing, tag, hit);
        if (!hit) miss_cycle_q.push_back(cycle + 2);   // table stage
        out_word_q.push_back({p4_ing, rtl_of_p4(p4_egr)});
        out_cycle_q.push_back(cycle + 3);
    end
endtask

task automatic send_one(input port_id_t rtl_ing, input flow_tag_t tag);
    drive_desc(rtl_ing, tag);
    @(negedge clk);
    user_metadata_in_valid = 1'b0;
endtask

// waits until every queued event has been seen, 20 cycles per event at most
task automatic wait_outputs();
    int idle;
    int pending;
    idle    = 0;
    pending = out_word_q.size() + drop_cycle_q.size() + miss_cycle_q.size();
    while (pending != 0) begin
        @(negedge clk);
        if (out_word_q.size() + drop_cycle_q.size() + miss_cycle_q.size() < pending) begin
            idle    = 0;
            pending = out_word_q.size() + drop_cycle_q.size() + miss_cycle_q.size();
        end else begin
            idle++;
        end
        if (idle > 20) report_error("timed out waiting for user_metadata_out_valid");
    end
endtask

function automatic flow_tag_t tag_from_set();
    return flow_tag_t'(($urandom % 4) * 8'h11);   // 00, 11, 22 or 33
endfunction

////////////////////////////////////////
// directed tests

task automatic idle_after_reset();
    for (int k = 0; k < 10; k++) begin
        @(negedge clk);
        assert (!user_metadata_out_valid && !ingress_drop && !table_miss)
            else report_error("valid or event output went high with no input after reset");
    end
endtask

task automatic default_forwarding();
    for (int k = 0; k < 11; k++) begin
        send_one(port_id_t'(k), flow_tag_t'(k * 3));   // empty table, all go to cpu
    end
    wait_outputs();
endtask

task automatic rule_priority();
    clear_rules();
    for (int k = 0; k < 11; k++) begin
        // key k sends to egress port 10-k, slots reused past 8
        write_rule(rule_idx_t'(k % 8), 1'b1, p4_tbl[k], flow_tag_t'(8'h40 + k), p4_tbl[10 - k]);
        send_one(port_id_t'(k), flow_tag_t'(8'h40 + k));
    end
    wait_outputs();
    write_rule(3'd2, 1'b1, p4_tbl[5], 8'h55, p4_tbl[1]);
    write_rule(3'd6, 1'b1, p4_tbl[5], 8'h55, p4_tbl[9]);   // same key, higher slot
    send_one(8'd5, 8'h55);
    wait_outputs();
    write_rule(3'd2, 1'b0, p4_tbl[5], 8'h55, p4_tbl[1]);   // slot 6 now wins
    send_one(8'd5, 8'h55);
    wait_outputs();
endtask

task automatic unknown_ids();
    clear_rules();
    send_one(8'd11, 8'h01);
    send_one(8'd12, 8'h02);
    send_one(8'hFF, 8'h03);
    write_rule(3'd3, 1'b1, p4_tbl[3], 8'h33, 8'd7);   // egress id with no rtl port
    send_one(8'd3, 8'h33);
    wait_outputs();
endtask

task automatic random_stream();
    clear_rules();
    for (int r = 0; r < NUM_RULES; r++) begin
        write_rule(rule_idx_t'(r), ($urandom % 4) != 0, p4_tbl[$urandom % 11],
                   tag_from_set(), p4_tbl[$urandom % 11]);
    end
    for (int n = 0; n < 40; n++) begin
        drive_desc(port_id_t'($urandom % 13), tag_from_set());   // back to back
        @(negedge clk);
    end
    user_metadata_in_valid = 1'b0;
    wait_outputs();
endtask

/* test/tb_p4_router.sv */
/* testbench for the metadata router that runs the directed tests and checks every
   output word, drop pulse and miss pulse against a model at its exact cycle */
`timescale 1ns/1ps

module tb_p4_router;

    import router_pkg::*;

    localparam port_id_t NO_MAP = 8'hFF;   // unmapped id in either direction

    logic           clk = 1'b0;
    logic           rst_n;
    user_metadata_t user_metadata_in;
    logic           user_metadata_in_valid;
    logic           rule_wr_en;
    rule_idx_t      rule_wr_idx;
    logic           rule_wr_enable_bit;
    port_id_t       rule_wr_ingress_id;
    flow_tag_t      rule_wr_flow_tag;
    port_id_t       rule_wr_egress_id;
    user_metadata_t user_metadata_out;
    logic           user_metadata_out_valid;
    logic           ingress_drop;
    logic           table_miss;

    always #2 clk = ~clk;   // 4 ns period

    p4_router_top dut_i (
        .clk                     ( clk                     ),
        .rst_n                   ( rst_n                   ),
        .user_metadata_in        ( user_metadata_in        ),
        .user_metadata_in_valid  ( user_metadata_in_valid  ),
        .rule_wr_en              ( rule_wr_en              ),
        .rule_wr_idx             ( rule_wr_idx             ),
        .rule_wr_enable_bit      ( rule_wr_enable_bit      ),
        .rule_wr_ingress_id      ( rule_wr_ingress_id      ),
        .rule_wr_flow_tag        ( rule_wr_flow_tag        ),
        .rule_wr_egress_id       ( rule_wr_egress_id       ),
        .user_metadata_out       ( user_metadata_out       ),
        .user_metadata_out_valid ( user_metadata_out_valid ),
        .ingress_drop            ( ingress_drop            ),
        .table_miss              ( table_miss              )
    );

    ////////////////////////////////////////
    // reference model

    // p4 id of each rtl port index 0 to 10
    port_id_t p4_tbl [0:10] = '{8'd0, 8'd20, 8'd21, 8'd40, 8'd41, 8'd60, 8'd61,
                                8'd80, 8'd81, 8'd82, 8'd83};

    logic      model_en  [NUM_RULES];   // mirror of the rule table
    port_id_t  model_ing [NUM_RULES];
    flow_tag_t model_tag [NUM_RULES];
    port_id_t  model_egr [NUM_RULES];

    user_metadata_t out_word_q   [$];   // expected words in arrival order
    int unsigned    out_cycle_q  [$];   // cycle each word is due
    int unsigned    drop_cycle_q [$];
    int unsigned    miss_cycle_q [$];
    int unsigned    cycle = 0;          // rising edges seen so far

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic port_id_t p4_of_rtl(input port_id_t idx);
        if (idx < 8'd11) begin
            return p4_tbl[idx[3:0]];
        end
        return NO_MAP;   // index 11 and up is dropped
    endfunction

    function automatic port_id_t rtl_of_p4(input port_id_t id);
        port_id_t idx;
        idx = NO_MAP;
        for (int k = 0; k < 11; k++) begin
            if (p4_tbl[k] == id) idx = port_id_t'(k);
        end
        return idx;
    endfunction

    // first enabled rule from slot 0 upward wins and a miss gives the cpu id
    function automatic port_id_t model_lookup(input port_id_t ing, input flow_tag_t tag,
                                              output logic hit);
        port_id_t egr;
        hit = 1'b0;
        egr = p4_tbl[0];
        for (int i = 0; i < NUM_RULES; i++) begin
            if (!hit && model_en[i] && model_ing[i] == ing && model_tag[i] == tag) begin
                hit = 1'b1;
                egr = model_egr[i];
            end
        end
        return egr;
    endfunction

    ////////////////////////////////////////
    // error reporting and output checker

    task automatic report_mismatch(input string sig, input logic [15:0] expected,
                                   input logic [15:0] actual);
        $display("FAIL time %0d ns: %s expected %h actual %h", $time, sig, expected, actual);
        $display("TEST FAIL");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_error(input string what);
        $display("ERROR at %0d ns: %s", $time, what);
        $display("TEST FAIL");
        $fatal(1, "stopping at first error");
    endtask

    // on every negedge each output must match what is due this cycle
    task automatic check_outputs();
        logic exp_v;
        logic exp_d;
        logic exp_m;
        exp_v = 1'b0;
        exp_d = 1'b0;
        exp_m = 1'b0;
        if (out_cycle_q.size() != 0) exp_v = (out_cycle_q[0] == cycle);
        if (drop_cycle_q.size() != 0) exp_d = (drop_cycle_q[0] == cycle);
        if (miss_cycle_q.size() != 0) exp_m = (miss_cycle_q[0] == cycle);
        assert (user_metadata_out_valid == exp_v)
            else report_mismatch("user_metadata_out_valid", 16'(exp_v),
                                 16'(user_metadata_out_valid));
        if (exp_v) begin
            assert (user_metadata_out == out_word_q[0])
                else report_mismatch("user_metadata_out", out_word_q[0], user_metadata_out);
            void'(out_word_q.pop_front());
            void'(out_cycle_q.pop_front());
        end
        assert (ingress_drop == exp_d)
            else report_mismatch("ingress_drop", 16'(exp_d), 16'(ingress_drop));
        if (exp_d) void'(drop_cycle_q.pop_front());
        assert (table_miss == exp_m)
            else report_mismatch("table_miss", 16'(exp_m), 16'(table_miss));
        if (exp_m) void'(miss_cycle_q.pop_front());
    endtask

    always @(negedge clk) begin
        if (rst_n) check_outputs();   // outputs sampled mid-cycle
    end

    `include "tb_router_tasks.svh"

    ////////////////////////////////////////
    // test sequence

    initial begin
        rst_n                  = 1'b0;
        user_metadata_in       = '0;
        user_metadata_in_valid = 1'b0;
        rule_wr_en             = 1'b0;
        rule_wr_idx            = '0;
        rule_wr_enable_bit     = 1'b0;
        rule_wr_ingress_id     = '0;
        rule_wr_flow_tag       = '0;
        rule_wr_egress_id      = '0;
        for (int i = 0; i < NUM_RULES; i++) begin
            model_en[i] = 1'b0;   // table comes out of reset empty
        end
        void'($urandom(32'h594));
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        idle_after_reset();
        default_forwarding();
        rule_priority();
        unknown_ids();
        random_stream();

        $display("TEST PASS");
        $finish;
    end

endmodule
